// File: logic/rv_pkg.sv
package rv_pkg;

    // Major opcodes
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_R3    = 7'b0110011;
    localparam logic [6:0] OP_LD    = 7'b0000011;
    localparam logic [6:0] OP_ST    = 7'b0100011;
    localparam logic [6:0] OP_BR    = 7'b1100011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;

    // Arithmetic funct3, shared by OP and OP-IMM
    localparam logic [2:0] ADD_SUB = 3'b000;
    localparam logic [2:0] SLL     = 3'b001;
    localparam logic [2:0] SLT     = 3'b010;
    localparam logic [2:0] SLTU    = 3'b011;
    localparam logic [2:0] XOR     = 3'b100;
    localparam logic [2:0] SRL_SRA = 3'b101;
    localparam logic [2:0] OR      = 3'b110;
    localparam logic [2:0] AND     = 3'b111;

    localparam logic [2:0] LB  = 3'b000;
    localparam logic [2:0] LH  = 3'b001;
    localparam logic [2:0] LW  = 3'b010;
    localparam logic [2:0] LBU = 3'b100;
    localparam logic [2:0] LHU = 3'b101;

    localparam logic [2:0] SB = 3'b000;
    localparam logic [2:0] SH = 3'b001;
    localparam logic [2:0] SW = 3'b010;

    localparam logic [2:0] BEQ  = 3'b000;
    localparam logic [2:0] BNE  = 3'b001;
    localparam logic [2:0] BLT  = 3'b100;
    localparam logic [2:0] BGE  = 3'b101;
    localparam logic [2:0] BLTU = 3'b110;
    localparam logic [2:0] BGEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_e;

    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

endpackage

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit import rv_pkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output logic       reg_write_enable,
    output logic       op_a_pc_sel,          // PC instead of rs1, AUIPC only
    output logic       op_b_imm_sel,         // Immediate instead of rs2
    output imm_type_e  imm_type,
    output alu_op_e    alu_op,
    output logic       mem_write_enable,
    output logic       mem_read_enable,
    output mem_size_e  mem_size,
    output logic       mem_unsigned,
    output logic       branch,
    output logic       jump,                 // JAL
    output logic       jump_reg,             // JALR
    output wb_sel_e    wb_sel,
    output logic       illegal
);

    // OP and OP-IMM share the funct3 map; only OP may select SUB
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub,
                                         input logic sra);
        case (f3)
            ADD_SUB: arith_op = sub ? ALU_SUB : ALU_ADD;
            SLL:     arith_op = ALU_SLL;
            SLT:     arith_op = ALU_SLT;
            SLTU:    arith_op = ALU_SLTU;
            XOR:     arith_op = ALU_XOR;
            SRL_SRA: arith_op = sra ? ALU_SRA : ALU_SRL;
            OR:      arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    endfunction

    always_comb begin
        reg_write_enable = 1'b0;
        op_a_pc_sel      = 1'b0;
        op_b_imm_sel     = 1'b0;
        imm_type         = IMM_I;
        alu_op           = ALU_ADD;
        mem_write_enable = 1'b0;
        mem_read_enable  = 1'b0;
        mem_size         = SIZE_WORD;
        mem_unsigned     = 1'b0;
        branch           = 1'b0;
        jump             = 1'b0;
        jump_reg         = 1'b0;
        wb_sel           = WB_ALU;
        illegal          = 1'b0;

        case (opcode)
            OP_IMM: begin
                reg_write_enable = 1'b1;
                op_b_imm_sel     = 1'b1;
                alu_op           = arith_op(funct3, 1'b0, funct7[5]);
            end
            OP_R3: begin
                reg_write_enable = 1'b1;
                alu_op           = arith_op(funct3, funct7[5], funct7[5]);
            end
            OP_LD: begin
                reg_write_enable = 1'b1;
                op_b_imm_sel     = 1'b1;
                mem_read_enable  = 1'b1;
                mem_unsigned     = funct3[2];
                wb_sel           = WB_MEM;
                case (funct3)
                    LB, LBU: mem_size = SIZE_BYTE;
                    LH, LHU: mem_size = SIZE_HALF;
                    LW:      mem_size = SIZE_WORD;
                    default: illegal  = 1'b1;
                endcase
            end
            OP_ST: begin
                op_b_imm_sel     = 1'b1;
                imm_type         = IMM_S;
                mem_write_enable = 1'b1;
                case (funct3)
                    SB:      mem_size = SIZE_BYTE;
                    SH:      mem_size = SIZE_HALF;
                    SW:      mem_size = SIZE_WORD;
                    default: illegal  = 1'b1;
                endcase
            end
            OP_BR: begin
                imm_type = IMM_B;
                branch   = 1'b1;
                case (funct3)                // Result bit 0 is the taken flag
                    BEQ:     alu_op  = ALU_EQ;
                    BNE:     alu_op  = ALU_NE;
                    BLT:     alu_op  = ALU_SLT;
                    BGE:     alu_op  = ALU_GE;
                    BLTU:    alu_op  = ALU_SLTU;
                    BGEU:    alu_op  = ALU_GEU;
                    default: illegal = 1'b1;
                endcase
            end
            OP_LUI: begin
                reg_write_enable = 1'b1;
                op_b_imm_sel     = 1'b1;
                imm_type         = IMM_U;
                alu_op           = ALU_PASS_B;
            end
            OP_AUIPC: begin
                reg_write_enable = 1'b1;
                op_a_pc_sel      = 1'b1;
                op_b_imm_sel     = 1'b1;
                imm_type         = IMM_U;
            end
            OP_JAL: begin
                reg_write_enable = 1'b1;
                imm_type         = IMM_J;
                jump             = 1'b1;
                wb_sel           = WB_PC4;
            end
            OP_JALR: begin
                reg_write_enable = 1'b1;
                op_b_imm_sel     = 1'b1;
                jump_reg         = 1'b1;     // Target is rs1 + imm from the ALU
                wb_sel           = WB_PC4;
                illegal          = (funct3 != 3'b000);
            end
            default: illegal = 1'b1;
        endcase

        // A flagged instruction retires as a no-op
        if (illegal) begin
            reg_write_enable = 1'b0;
            mem_write_enable = 1'b0;
            mem_read_enable  = 1'b0;
            branch           = 1'b0;
            jump             = 1'b0;
            jump_reg         = 1'b0;
        end
    end

endmodule

// File: logic/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import rv_pkg::*; (
    input  logic [31:0] instr,
    input  imm_type_e   imm_type,
    output logic [31:0] imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_type)
            IMM_I: imm = {{20{sign}}, instr[31:20]};
            IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            IMM_B: imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_U: imm = {instr[31:12], 12'b0};            // Upper 20 bits, low bits zero
            IMM_J: imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = 32'd0;
        endcase
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  logic [31:0] op_a,
    input  logic [31:0] op_b,
    input  alu_op_e     alu_op,
    output logic [31:0] result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = op_b[4:0];
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = {31'd0, lt_signed};      // Also BLT
            ALU_SLTU:   result = {31'd0, lt_unsigned};    // Also BLTU
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_EQ:     result = {31'd0, op_a == op_b};
            ALU_NE:     result = {31'd0, op_a != op_b};
            ALU_GE:     result = {31'd0, !lt_signed};
            ALU_GEU:    result = {31'd0, !lt_unsigned};
            ALU_PASS_B: result = op_b;                    // LUI
            default:    result = 32'd0;
        endcase
    end

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        write_enable,
    input  logic [4:0]  rd_addr,
    input  logic [31:0] rd_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (write_enable && rd_addr != 5'd0) begin    // x0 stays zero
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // x0 reads zero on both ports
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_addr != 5'd0 || rs1_data == 32'd0) && (rs2_addr != 5'd0 || rs2_data == 32'd0));

endmodule

// File: logic/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import rv_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] addr,
    input  logic [31:0] store_data,
    input  logic        write_enable,
    input  logic        read_enable,
    input  mem_size_e   size,
    input  logic        is_unsigned,
    output logic [31:0] load_data
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]   mem [DMEM_WORDS];
    logic [AW-1:0] word_idx;
    logic [1:0]    byte_off;
    logic [3:0]    lane_en;
    logic [31:0]   lane_data;
    logic [31:0]   shifted;

    assign word_idx = addr[AW+1:2];      // Wraps modulo DMEM_WORDS
    assign byte_off = addr[1:0];

    // Replicate the store data so every lane holds it, then enable only the addressed lanes
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                lane_en   = 4'b0001 << byte_off;
                lane_data = {4{store_data[7:0]}};
            end
            SIZE_HALF: begin
                lane_en   = 4'b0011 << byte_off;
                lane_data = {2{store_data[15:0]}};
            end
            default: begin
                lane_en   = 4'b1111;
                lane_data = store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (write_enable) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en[i]) mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end
    end

    assign shifted = mem[word_idx] >> {byte_off, 3'b000};     // Addressed lane to bit 0

    always_comb begin
        case (size)
            SIZE_BYTE: load_data = {{24{!is_unsigned && shifted[7]}}, shifted[7:0]};
            SIZE_HALF: load_data = {{16{!is_unsigned && shifted[15]}}, shifted[15:0]};
            default:   load_data = shifted;
        endcase
    end

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (write_enable || read_enable) |->
            (size == SIZE_BYTE) || (size == SIZE_HALF && !addr[0]) || (addr[1:0] == 2'b00));

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
    parameter int          DMEM_WORDS = 64,
    parameter logic [31:0] RESET_PC   = 32'h0000_0100
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  logic        instr_req,
    output logic        instr_ack,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [31:0] retire_next_pc,
    output logic        retire_we,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_data,
    output logic        retire_illegal
);

    typedef enum logic {IDLE, WAIT_LOW} state_e;

    state_e      state;
    logic [31:0] pc;
    logic        exec;
    logic        reg_write_enable, op_a_pc_sel, op_b_imm_sel;
    logic        mem_write_enable, mem_read_enable, mem_unsigned;
    logic        branch, jump, jump_reg, illegal;
    imm_type_e   imm_type;
    alu_op_e     alu_op;
    mem_size_e   mem_size;
    wb_sel_e     wb_sel;
    logic [31:0] imm, rs1_data, rs2_data, op_a, op_b, alu_result, load_data;
    logic [31:0] pc_plus4, wb_data, next_pc;

    assign exec = (state == IDLE) && instr_req;    // Single execute edge per handshake

    control_unit u_ctrl (
        .opcode(instr[6:0]), .funct3(instr[14:12]), .funct7(instr[31:25]),
        .reg_write_enable, .op_a_pc_sel, .op_b_imm_sel, .imm_type, .alu_op,
        .mem_write_enable, .mem_read_enable, .mem_size, .mem_unsigned,
        .branch, .jump, .jump_reg, .wb_sel, .illegal
    );

    imm_gen u_imm (.instr, .imm_type, .imm);

    register_file u_rf (
        .clk, .rst_n, .rs1_addr(instr[19:15]), .rs2_addr(instr[24:20]), .rs1_data, .rs2_data,
        .write_enable(reg_write_enable && exec), .rd_addr(instr[11:7]), .rd_data(wb_data)
    );

    assign op_a = op_a_pc_sel ? pc : rs1_data;
    assign op_b = op_b_imm_sel ? imm : rs2_data;

    alu u_alu (.op_a, .op_b, .alu_op, .result(alu_result));

    load_store_unit #(.DMEM_WORDS(DMEM_WORDS)) u_lsu (
        .clk, .rst_n, .addr(alu_result), .store_data(rs2_data),
        .write_enable(mem_write_enable && exec), .read_enable(mem_read_enable && exec),
        .size(mem_size), .is_unsigned(mem_unsigned), .load_data
    );

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = load_data;
            WB_PC4:  wb_data = pc_plus4;     // Link address for JAL and JALR
            default: wb_data = alu_result;
        endcase
    end

    always_comb begin
        if (jump_reg) next_pc = {alu_result[31:1], 1'b0};
        else if (jump || (branch && alu_result[0])) next_pc = pc + imm;
        else next_pc = pc_plus4;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= IDLE;
            pc             <= RESET_PC;
            retire_we      <= 1'b0;
            retire_illegal <= 1'b0;
        end else if (exec) begin
            state          <= WAIT_LOW;
            pc             <= next_pc;
            retire_we      <= reg_write_enable;
            retire_illegal <= illegal;
        end else if (state == WAIT_LOW && !instr_req) begin
            state <= IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (exec) begin
            retire_pc      <= pc;
            retire_next_pc <= next_pc;
            retire_rd      <= instr[11:7];
            retire_data    <= wb_data;
        end
    end

    assign instr_ack    = (state == WAIT_LOW);
    assign retire_valid = (state == WAIT_LOW);

    a_ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        instr_ack && instr_req |=> instr_ack);

endmodule

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    localparam int NUM_ROWS    = 54;
    localparam int WATCHDOG_NS = (NUM_ROWS * 12 + 20) * 8;
    localparam int ACK_WAIT    = 10;       // Cycles allowed for each ack edge

    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_LD    = 7'b0000011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic        instr_req;
    logic        instr_ack;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [31:0] retire_next_pc;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        retire_illegal;

    logic [31:0] tab_instr [NUM_ROWS];
    logic        tab_we    [NUM_ROWS];
    logic [4:0]  tab_rd    [NUM_ROWS];
    logic [31:0] tab_data  [NUM_ROWS];
    logic [31:0] tab_npc   [NUM_ROWS];
    logic        tab_ill   [NUM_ROWS];
    int          n_rows;
    int          errors;
    logic [31:0] exp_pc;
    logic [31:0] rng;
    logic        abort;

    rv_core #(.DMEM_WORDS(64), .RESET_PC(32'h0000_0100)) UUT (
        .clk, .rst_n, .instr, .instr_req, .instr_ack, .retire_valid, .retire_pc,
        .retire_next_pc, .retire_we, .retire_rd, .retire_data, .retire_illegal
    );

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_R};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input logic [31:0] word, input int we, input int rd,
                           input logic [31:0] data, input logic [31:0] npc, input int ill);
        tab_instr[n_rows] = word;
        tab_we[n_rows]    = we[0];
        tab_rd[n_rows]    = rd[4:0];
        tab_data[n_rows]  = data;
        tab_npc[n_rows]   = npc;
        tab_ill[n_rows]   = ill[0];
        n_rows++;
    endtask

    // Register state after each row: x1=5, x2=-3, x5=0xfa, x6=0x35, x8=0x50
    task automatic build_table();
        add_row(enc_i(5, 0, 0, 1, OPC_IMM), 1, 1, 32'h0000_0005, 32'h104, 0);     // ADDI
        add_row(enc_i(-3, 0, 0, 2, OPC_IMM), 1, 2, 32'hffff_fffd, 32'h108, 0);
        add_row(enc_i(1, 2, 2, 3, OPC_IMM), 1, 3, 32'h0000_0001, 32'h10c, 0);     // SLTI
        add_row(enc_i(1, 2, 3, 4, OPC_IMM), 1, 4, 32'h0000_0000, 32'h110, 0);     // SLTIU
        add_row(enc_i('hff, 1, 4, 5, OPC_IMM), 1, 5, 32'h0000_00fa, 32'h114, 0);  // XORI
        add_row(enc_i('h30, 1, 6, 6, OPC_IMM), 1, 6, 32'h0000_0035, 32'h118, 0);  // ORI
        add_row(enc_i('hf0, 2, 7, 7, OPC_IMM), 1, 7, 32'h0000_00f0, 32'h11c, 0);  // ANDI
        add_row(enc_i(4, 1, 1, 8, OPC_IMM), 1, 8, 32'h0000_0050, 32'h120, 0);     // SLLI
        add_row(enc_i(4, 2, 5, 9, OPC_IMM), 1, 9, 32'h0fff_ffff, 32'h124, 0);     // SRLI
        add_row(enc_i('h401, 2, 5, 10, OPC_IMM), 1, 10, 32'hffff_fffe, 32'h128, 0); // SRAI
        add_row(enc_r(0, 2, 1, 0, 11), 1, 11, 32'h0000_0002, 32'h12c, 0);         // ADD
        add_row(enc_r('h20, 2, 1, 0, 12), 1, 12, 32'h0000_0008, 32'h130, 0);      // SUB
        add_row(enc_r(0, 1, 1, 1, 13), 1, 13, 32'h0000_00a0, 32'h134, 0);         // SLL
        add_row(enc_r(0, 1, 2, 2, 14), 1, 14, 32'h0000_0001, 32'h138, 0);         // SLT
        add_row(enc_r(0, 1, 2, 3, 15), 1, 15, 32'h0000_0000, 32'h13c, 0);         // SLTU
        add_row(enc_r(0, 2, 1, 4, 16), 1, 16, 32'hffff_fff8, 32'h140, 0);         // XOR
        add_row(enc_r(0, 1, 2, 5, 17), 1, 17, 32'h07ff_ffff, 32'h144, 0);         // SRL
        add_row(enc_r('h20, 1, 2, 5, 18), 1, 18, 32'hffff_ffff, 32'h148, 0);      // SRA
        add_row(enc_r(0, 8, 1, 6, 19), 1, 19, 32'h0000_0055, 32'h14c, 0);         // OR
        add_row(enc_r(0, 6, 2, 7, 20), 1, 20, 32'h0000_0035, 32'h150, 0);         // AND
        add_row(enc_i(7, 1, 0, 0, OPC_IMM), 1, 0, 32'h0000_000c, 32'h154, 0);     // Write x0
        add_row(enc_r(0, 0, 0, 0, 21), 1, 21, 32'h0000_0000, 32'h158, 0);         // Read x0
        add_row(enc_u('h12345, 22, OPC_LUI), 1, 22, 32'h1234_5000, 32'h15c, 0);
        add_row(enc_i('h678, 22, 0, 22, OPC_IMM), 1, 22, 32'h1234_5678, 32'h160, 0);
        add_row(enc_s('h40, 22, 0, 2), 0, 0, 32'h0, 32'h164, 0);                  // SW
        add_row(enc_i('h40, 0, 2, 23, OPC_LD), 1, 23, 32'h1234_5678, 32'h168, 0); // LW
        add_row(enc_s('h42, 2, 0, 1), 0, 0, 32'h0, 32'h16c, 0);                   // SH
        add_row(enc_i('h42, 0, 1, 24, OPC_LD), 1, 24, 32'hffff_fffd, 32'h170, 0); // LH
        add_row(enc_i('h42, 0, 5, 25, OPC_LD), 1, 25, 32'h0000_fffd, 32'h174, 0); // LHU
        add_row(enc_s('h41, 5, 0, 0), 0, 0, 32'h0, 32'h178, 0);                   // SB
        add_row(enc_i('h41, 0, 0, 26, OPC_LD), 1, 26, 32'hffff_fffa, 32'h17c, 0); // LB
        add_row(enc_i('h41, 0, 4, 27, OPC_LD), 1, 27, 32'h0000_00fa, 32'h180, 0); // LBU
        add_row(enc_i('h40, 0, 2, 28, OPC_LD), 1, 28, 32'hfffd_fa78, 32'h184, 0);
        add_row(enc_i('h40, 0, 0, 29, OPC_LD), 1, 29, 32'h0000_0078, 32'h188, 0);
        add_row(enc_i('h40, 0, 1, 30, OPC_LD), 1, 30, 32'hffff_fa78, 32'h18c, 0);
        add_row(enc_b(8, 1, 1, 0), 0, 0, 32'h0, 32'h194, 0);                      // BEQ taken
        add_row(enc_b(8, 2, 1, 0), 0, 0, 32'h0, 32'h198, 0);
        add_row(enc_b(12, 2, 1, 1), 0, 0, 32'h0, 32'h1a4, 0);                     // BNE taken
        add_row(enc_b(12, 1, 1, 1), 0, 0, 32'h0, 32'h1a8, 0);
        add_row(enc_b(16, 1, 2, 4), 0, 0, 32'h0, 32'h1b8, 0);                     // BLT taken
        add_row(enc_b(16, 2, 1, 4), 0, 0, 32'h0, 32'h1bc, 0);
        add_row(enc_b(-8, 2, 1, 5), 0, 0, 32'h0, 32'h1b4, 0);                     // BGE taken
        add_row(enc_b(-8, 1, 2, 5), 0, 0, 32'h0, 32'h1b8, 0);
        add_row(enc_b(20, 2, 1, 6), 0, 0, 32'h0, 32'h1cc, 0);                     // BLTU taken
        add_row(enc_b(20, 1, 2, 6), 0, 0, 32'h0, 32'h1d0, 0);
        add_row(enc_b(24, 1, 2, 7), 0, 0, 32'h0, 32'h1e8, 0);                     // BGEU taken
        add_row(enc_b(24, 2, 1, 7), 0, 0, 32'h0, 32'h1ec, 0);
        add_row(enc_u(1, 3, OPC_AUIPC), 1, 3, 32'h0000_11ec, 32'h1f0, 0);
        add_row(enc_j('h20, 4), 1, 4, 32'h0000_01f4, 32'h210, 0);                 // JAL forward
        add_row(enc_j(-16, 5), 1, 5, 32'h0000_0214, 32'h200, 0);                  // JAL back
        add_row(enc_i('h300, 1, 0, 6, OPC_JALR), 1, 6, 32'h0000_0204, 32'h304, 0);
        add_row(enc_i('hfc, 1, 0, 7, OPC_JALR), 1, 7, 32'h0000_0308, 32'h100, 0); // Odd target
        add_row(32'h0000_007f, 0, 0, 32'h0, 32'h104, 1);                          // Unknown opcode
        add_row(enc_r(0, 4, 6, 0, 9), 1, 9, 32'h0000_03f8, 32'h108, 0);           // Link values
    endtask

    task automatic report_mismatch(input int row, input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("ERR row %0d %s expected %h got %h", row, name, exp, act);
    endtask

    // Polls one cycle at a time until instr_ack reaches the wanted level
    task automatic wait_ack(input logic level, output logic ok);
        int waited;
        waited = 0;
        while (instr_ack !== level && waited < ACK_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        ok = (instr_ack === level);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all instructions were handshaken");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic       ok;
        logic [1:0] gap;
        logic [1:0] hold;
        rst_n     = 1'b0;
        instr     = 32'd0;
        instr_req = 1'b0;
        errors    = 0;
        n_rows    = 0;
        abort     = 1'b0;
        exp_pc    = 32'h0000_0100;
        rng       = 32'h8e26;
        build_table();

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        if (instr_ack !== 1'b0) report_mismatch(-1, "instr_ack", 32'h0, 32'(instr_ack));
        if (retire_valid !== 1'b0) report_mismatch(-1, "retire_valid", 32'h0, 32'(retire_valid));
        if (retire_we !== 1'b0) report_mismatch(-1, "retire_we", 32'h0, 32'(retire_we));
        if (retire_illegal !== 1'b0) begin
            report_mismatch(-1, "retire_illegal", 32'h0, 32'(retire_illegal));
        end

        for (int i = 0; i < n_rows && !abort; i++) begin
            rng  = xorshift32(rng);
            gap  = rng[1:0];
            rng  = xorshift32(rng);
            hold = rng[1:0];
            repeat (gap) begin
                @(posedge clk);
                #1;
                if (instr_ack !== 1'b0) begin
                    errors++;
                    $display("Row %0d: instr_ack went high with no request pending", i);
                end
            end

            instr     = tab_instr[i];
            instr_req = 1'b1;
            wait_ack(1'b1, ok);
            if (!ok) begin
                errors++;
                abort = 1'b1;
                $display("Row %0d: instr_ack never rose after instr_req was raised", i);
            end else begin
                if (retire_valid !== 1'b1) begin
                    report_mismatch(i, "retire_valid", 32'h1, 32'(retire_valid));
                end
                if (retire_pc !== exp_pc) report_mismatch(i, "retire_pc", exp_pc, retire_pc);
                if (retire_next_pc !== tab_npc[i]) begin
                    report_mismatch(i, "retire_next_pc", tab_npc[i], retire_next_pc);
                end
                if (retire_we !== tab_we[i]) begin
                    report_mismatch(i, "retire_we", 32'(tab_we[i]), 32'(retire_we));
                end
                if (retire_illegal !== tab_ill[i]) begin
                    report_mismatch(i, "retire_illegal", 32'(tab_ill[i]), 32'(retire_illegal));
                end
                if (tab_we[i] && retire_rd !== tab_rd[i]) begin
                    report_mismatch(i, "retire_rd", 32'(tab_rd[i]), 32'(retire_rd));
                end
                if (tab_we[i] && retire_data !== tab_data[i]) begin
                    report_mismatch(i, "retire_data", tab_data[i], retire_data);
                end
                exp_pc = tab_npc[i];

                repeat (hold) begin
                    @(posedge clk);
                    #1;
                    if (instr_ack !== 1'b1) begin
                        errors++;
                        $display("Row %0d: instr_ack fell while instr_req was still high", i);
                    end
                end
                instr_req = 1'b0;
                wait_ack(1'b0, ok);
                if (!ok) begin
                    errors++;
                    abort = 1'b1;
                    $display("Row %0d: instr_ack stayed high after instr_req was lowered", i);
                end else if (retire_valid !== 1'b0) begin
                    report_mismatch(i, "retire_valid", 32'h0, 32'(retire_valid));
                end
            end
        end

        $display("Finished %0d instructions with %0d errors", n_rows, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
logic/rv_pkg.sv
logic/control_unit.sv
logic/imm_gen.sv
logic/alu.sv
logic/register_file.sv
logic/load_store_unit.sv
logic/rv_core.sv
verification/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
